/* sim.f */
design/bus_pkg.sv
design/bus_addr_decode.sv
design/bus_ram.sv
design/bus_gpio.sv
design/bus_timer.sv
design/bus_resp_mux.sv
design/sys_bus_top.sv
sim/tb_sys_bus.sv

/* Makefile */
TOP := tb_sys_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --assert --top-module $(TOP) -f sim.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

/* sim/tb_sys_bus.sv */
// Directed testbench for the system bus, run as top with the RTL from sim.f
`default_nettype none

module tb_sys_bus;

  localparam int RamDepthWords = 1024;
  localparam int GpiWidth      = 8;
  localparam int GpoWidth      = 16;
  localparam int ClkPeriod     = 10;
  localparam int ResetCycles   = 8;
  localparam int NumTests      = 5;
  localparam int LongestTest   = 200;
  localparam int MarginCycles  = 100;
  localparam int RamWords      = 16;

  logic                clk_sys;
  logic                rst_sys_n;
  bus_pkg::bus_req_t   req;
  bus_pkg::bus_resp_t  resp;
  logic [GpiWidth-1:0] gp_in;
  logic [GpoWidth-1:0] gp_out;
  logic                irq_timer;

  logic [31:0] lfsr_q;
  logic [31:0] ram_model [RamDepthWords];
  bit          ram_known [RamDepthWords];
  int          err_count;
  int          check_count;

  sys_bus_top #(
    .RamDepthWords(RamDepthWords),
    .GpiWidth     (GpiWidth),
    .GpoWidth     (GpoWidth)
  ) i_dut (
    .clk_sys_i  (clk_sys),
    .rst_sys_ni (rst_sys_n),
    .req_i      (req),
    .resp_o     (resp),
    .gp_i       (gp_in),
    .gp_o       (gp_out),
    .irq_timer_o(irq_timer)
  );

  initial begin
    clk_sys = 1'b0;
    forever #(ClkPeriod / 2) clk_sys = ~clk_sys;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic bus_pkg::bus_resp_t resp_of(input logic err, input logic [31:0] rdata);
    bus_pkg::bus_resp_t r;
    r.rvalid = 1'b1;
    r.err    = err;
    r.rdata  = rdata;
    return r;
  endfunction

  task automatic check_resp(input string what, input bus_pkg::bus_resp_t got,
                            input bus_pkg::bus_resp_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch resp_o (%s): got 0x%h expected 0x%h", what, got, exp);
    end
  endtask

  task automatic check_irq(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch irq_timer_o (%s): got 0x%h expected 0x%h", what, got, exp);
    end
  endtask

  task automatic check_gpo(input string what, input logic [GpoWidth-1:0] got,
                           input logic [GpoWidth-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch gp_o (%s): got 0x%h expected 0x%h", what, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk_sys);
  endtask

  // Starts at a falling edge, returns at the next one with the response stable
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output bus_pkg::bus_resp_t got);
    req.valid = 1'b1;
    req.we    = we;
    req.be    = be;
    req.addr  = addr;
    req.wdata = wdata;
    @(negedge clk_sys);
    got = resp;
    req = '0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [3:0] be, input logic [31:0] d);
    bus_pkg::bus_resp_t got;
    bus_access(1'b1, be, addr, d, got);
    check_resp("write", got, resp_of(1'b0, '0));
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp);
    bus_pkg::bus_resp_t got;
    bus_access(1'b0, 4'hF, addr, '0, got);
    check_resp("read", got, resp_of(1'b0, exp));
  endtask

  // After one idle cycle nothing may be left on the response
  task automatic idle_check();
    idle(1);
    check_resp("idle", resp, '0);
  endtask

  task automatic ram_write(input logic [9:0] idx, input logic [3:0] be, input logic [31:0] d);
    write_word(bus_pkg::RamBase | {20'd0, idx, 2'b00}, be, d);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) ram_model[idx][b*8 +: 8] = d[b*8 +: 8];
    end
    ram_known[idx] = 1'b1;
  endtask

  task automatic ram_read(input logic [9:0] idx);
    read_check(bus_pkg::RamBase | {20'd0, idx, 2'b00}, ram_model[idx]);
  endtask

  task automatic test_ram_bytes();
    logic [9:0] idx;
    for (int n = 0; n < RamWords; n++) begin
      idx = 10'(rand_bits(10));
      ram_write(idx, 4'hF, rand_bits(32));
      idle_check();
      ram_write(idx, 4'(rand_bits(4)), rand_bits(32));
      idle_check();
      ram_read(idx);
      idle_check();
    end
  endtask

  // No idle cycles between requests
  task automatic test_back_to_back();
    logic [9:0] idx;
    for (int n = 0; n < 2 * RamWords; n++) begin
      idx = 10'h100 + 10'(rand_bits(2));
      if (!ram_known[idx]) ram_write(idx, 4'hF, rand_bits(32));
      else if (rand_bits(1) == 32'd1) ram_write(idx, 4'(rand_bits(4)), rand_bits(32));
      else ram_read(idx);
    end
    idle_check();
  endtask

  task automatic test_gpio();
    logic [31:0]         d;
    logic [GpoWidth-1:0] exp_gpo;
    d = rand_bits(32);
    write_word(bus_pkg::GpioBase, 4'hF, d);
    exp_gpo = d[GpoWidth-1:0];
    check_gpo("full write", gp_out, exp_gpo);
    read_check(bus_pkg::GpioBase, {16'd0, exp_gpo});
    d = rand_bits(32);
    write_word(bus_pkg::GpioBase, 4'b0010, d);
    exp_gpo[15:8] = d[15:8];
    check_gpo("byte write", gp_out, exp_gpo);
    read_check(bus_pkg::GpioBase, {16'd0, exp_gpo});
    gp_in = GpiWidth'(rand_bits(GpiWidth));
    // Two synchroniser stages
    idle(2);
    read_check(bus_pkg::GpioBase + 32'h4, {24'd0, gp_in});
    write_word(bus_pkg::GpioBase + 32'h4, 4'hF, ~d);
    check_gpo("input write", gp_out, exp_gpo);
    read_check(bus_pkg::GpioBase + 32'h4, {24'd0, gp_in});
  endtask

  task automatic test_timer();
    bus_pkg::bus_resp_t got;
    logic [31:0]        c0;
    logic [31:0]        cmp;
    bus_access(1'b0, 4'hF, bus_pkg::TimerBase, '0, got);
    c0 = got.rdata;
    check_resp("count flags", got, resp_of(1'b0, c0));
    // Next cycle, one increment later
    bus_access(1'b0, 4'hF, bus_pkg::TimerBase, '0, got);
    check_resp("count step", got, resp_of(1'b0, c0 + 32'd1));
    cmp = c0 + 32'd41;
    write_word(bus_pkg::TimerBase + 32'h4, 4'hF, cmp);
    check_irq("after compare write", irq_timer, 1'b0);
    read_check(bus_pkg::TimerBase + 32'h4, cmp);
    idle(60);
    check_irq("compare reached", irq_timer, 1'b1);
    write_word(bus_pkg::TimerBase + 32'h4, 4'hF, '1);
    idle(2);
    check_irq("compare cleared", irq_timer, 1'b0);
    read_check(bus_pkg::TimerBase + 32'h4, '1);
  endtask

  task automatic test_unmapped();
    bus_pkg::bus_resp_t got;
    bus_access(1'b0, 4'hF, 32'h4000_0000, '0, got);
    check_resp("unmapped read", got, resp_of(1'b1, '0));
    bus_access(1'b1, 4'hF, 32'h8000_1000, rand_bits(32), got);
    check_resp("unmapped write", got, resp_of(1'b1, '0));
    idle_check();
    write_word(bus_pkg::RamBase + 32'h20, 4'hF, rand_bits(32));
    idle_check();
  endtask

  initial begin
    #((ResetCycles + NumTests * LongestTest + MarginCycles) * ClkPeriod);
    $display("Timeout: the tests did not finish, checks=%0d errors=%0d",
             check_count, err_count);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    lfsr_q      = 32'h3d749c78;
    err_count   = 0;
    check_count = 0;
    rst_sys_n   = 1'b0;
    req         = '0;
    gp_in       = '0;
    idle(ResetCycles);
    rst_sys_n = 1'b1;
    check_gpo("reset", gp_out, '0);
    check_irq("reset", irq_timer, 1'b0);
    check_resp("reset", resp, '0);
    test_ram_bytes();
    test_back_to_back();
    test_gpio();
    test_timer();
    test_unmapped();
    $display("checks=%0d errors=%0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/sys_bus_top.sv */
// System bus top level connecting address decode, RAM, GPIO, timer and response stage
`default_nettype none

module sys_bus_top #(
  parameter int RamDepthWords = 1024,
  parameter int GpiWidth      = 8,
  parameter int GpoWidth      = 16
) (
  input  wire                       clk_sys_i,
  input  wire                       rst_sys_ni,
  input  wire bus_pkg::bus_req_t    req_i,
  output bus_pkg::bus_resp_t        resp_o,
  input  wire  [GpiWidth-1:0]       gp_i,
  output logic [GpoWidth-1:0]       gp_o,
  output logic                      irq_timer_o
);

  logic [bus_pkg::NumDevices-1:0] dev_sel;
  logic                           pend_valid;
  bus_pkg::bus_device_e           pend_dev;
  logic                           pend_we;
  logic [bus_pkg::DataWidth-1:0]  ram_rdata;
  logic [bus_pkg::DataWidth-1:0]  gpio_rdata;
  logic [bus_pkg::DataWidth-1:0]  timer_rdata;

  bus_addr_decode u_decode (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .req_i       (req_i),
    .dev_sel_o   (dev_sel),
    .pend_valid_o(pend_valid),
    .pend_dev_o  (pend_dev),
    .pend_we_o   (pend_we)
  );

  bus_ram #(
    .RamDepthWords(RamDepthWords)
  ) u_ram (
    .clk_sys_i(clk_sys_i),
    .sel_i    (dev_sel[bus_pkg::DevRam]),
    .req_i    (req_i),
    .rdata_o  (ram_rdata)
  );

  bus_gpio #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .sel_i     (dev_sel[bus_pkg::DevGpio]),
    .req_i     (req_i),
    .gp_i      (gp_i),
    .gp_o      (gp_o),
    .rdata_o   (gpio_rdata)
  );

  bus_timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .sel_i      (dev_sel[bus_pkg::DevTimer]),
    .req_i      (req_i),
    .rdata_o    (timer_rdata),
    .irq_timer_o(irq_timer_o)
  );

  bus_resp_mux u_resp (
    .pend_valid_i (pend_valid),
    .pend_dev_i   (pend_dev),
    .pend_we_i    (pend_we),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .timer_rdata_i(timer_rdata),
    .resp_o       (resp_o)
  );

endmodule

`default_nettype wire

/* design/bus_resp_mux.sv */
// Result stage: builds the host response from the pending access and device read data
`default_nettype none

module bus_resp_mux (
  input  wire                               pend_valid_i,
  input  wire bus_pkg::bus_device_e         pend_dev_i,
  input  wire                               pend_we_i,
  input  wire  [bus_pkg::DataWidth-1:0]     ram_rdata_i,
  input  wire  [bus_pkg::DataWidth-1:0]     gpio_rdata_i,
  input  wire  [bus_pkg::DataWidth-1:0]     timer_rdata_i,
  output bus_pkg::bus_resp_t                resp_o
);

  always_comb begin
    resp_o.rvalid = pend_valid_i;
    resp_o.err    = pend_valid_i && (pend_dev_i == bus_pkg::DevNone);
    resp_o.rdata  = '0;

    // Writes and errors carry no data
    if (pend_valid_i && !pend_we_i) begin
      case (pend_dev_i)
        bus_pkg::DevRam:   resp_o.rdata = ram_rdata_i;
        bus_pkg::DevGpio:  resp_o.rdata = gpio_rdata_i;
        bus_pkg::DevTimer: resp_o.rdata = timer_rdata_i;
        default:           resp_o.rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/bus_timer.sv */
// Timer device: free-running counter and compare register driving a registered interrupt
`default_nettype none

module bus_timer (
  input  wire                              clk_sys_i,
  input  wire                              rst_sys_ni,
  input  wire                              sel_i,
  input  wire bus_pkg::bus_req_t           req_i,
  output logic [bus_pkg::DataWidth-1:0]    rdata_o,
  output logic                             irq_timer_o
);

  localparam int NumBytes = bus_pkg::DataWidth / 8;

  bus_pkg::timer_reg_e           reg_sel;
  logic                          count_we;
  logic                          compare_we;
  logic [bus_pkg::DataWidth-1:0] wmask;
  logic [bus_pkg::DataWidth-1:0] count_q;
  logic [bus_pkg::DataWidth-1:0] compare_q;

  assign reg_sel    = bus_pkg::timer_reg_e'(req_i.addr[2]);
  assign count_we   = sel_i && req_i.we && (reg_sel == bus_pkg::TimerCount);
  assign compare_we = sel_i && req_i.we && (reg_sel == bus_pkg::TimerCompare);

  // Byte enables widened to a bit mask
  always_comb begin
    for (int b = 0; b < NumBytes; b++) begin
      wmask[b*8 +: 8] = {8{req_i.be[b]}};
    end
  end

  // A write takes the place of the increment in that cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      count_q <= '0;
    end else if (count_we) begin
      count_q <= (count_q & ~wmask) | (req_i.wdata & wmask);
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  // All ones keeps the interrupt quiet after reset
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      compare_q <= '1;
    end else if (compare_we) begin
      compare_q <= (compare_q & ~wmask) | (req_i.wdata & wmask);
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      irq_timer_o <= 1'b0;
    end else begin
      irq_timer_o <= (count_q >= compare_q);
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (sel_i && !req_i.we) begin
      case (reg_sel)
        bus_pkg::TimerCount: rdata_o <= count_q;
        default:             rdata_o <= compare_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/bus_gpio.sv */
// GPIO device with a byte-writable output register and a two-flop synchronised input
`default_nettype none

module bus_gpio #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  wire                              clk_sys_i,
  input  wire                              rst_sys_ni,
  input  wire                              sel_i,
  input  wire bus_pkg::bus_req_t           req_i,
  input  wire  [GpiWidth-1:0]              gp_i,
  output logic [GpoWidth-1:0]              gp_o,
  output logic [bus_pkg::DataWidth-1:0]    rdata_o
);

  bus_pkg::gpio_reg_e  reg_sel;
  logic                gpo_we;
  logic [GpiWidth-1:0] gp_meta_q;
  logic [GpiWidth-1:0] gp_sync_q;

  assign reg_sel = bus_pkg::gpio_reg_e'(req_i.addr[2]);

  // Writes to the input register are dropped
  assign gpo_we = sel_i && req_i.we && (reg_sel == bus_pkg::GpioOut);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_meta_q <= '0;
      gp_sync_q <= '0;
    end else begin
      gp_meta_q <= gp_i;
      gp_sync_q <= gp_meta_q;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o <= '0;
    end else if (gpo_we) begin
      for (int i = 0; i < GpoWidth; i++) begin
        if (req_i.be[i/8]) begin
          gp_o[i] <= req_i.wdata[i];
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (sel_i && !req_i.we) begin
      case (reg_sel)
        bus_pkg::GpioOut: rdata_o <= bus_pkg::DataWidth'(gp_o);
        default:          rdata_o <= bus_pkg::DataWidth'(gp_sync_q);
      endcase
    end
  end

  a_gpo_only_on_write: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !gpo_we |=> $stable(gp_o));

endmodule

`default_nettype wire

/* design/bus_ram.sv */
// Byte-enabled single-port RAM device, answering reads with registered data
`default_nettype none

module bus_ram #(
  parameter int RamDepthWords = 1024
) (
  input  wire                              clk_sys_i,
  input  wire                              sel_i,
  input  wire bus_pkg::bus_req_t           req_i,
  output logic [bus_pkg::DataWidth-1:0]    rdata_o
);

  localparam int IdxWidth  = $clog2(RamDepthWords);
  localparam int NumBytes  = bus_pkg::DataWidth / 8;

  logic [bus_pkg::DataWidth-1:0] mem_q [RamDepthWords];

  // Word offset within the 4 KiB window
  logic [9:0]          word_off;
  logic [IdxWidth-1:0] word_idx;

  assign word_off = req_i.addr[11:2];

  // Wraps when the depth is smaller than the window
  assign word_idx = IdxWidth'(word_off % RamDepthWords);

  always_ff @(posedge clk_sys_i) begin
    if (sel_i && req_i.we) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (req_i.be[b]) begin
          mem_q[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read data holds its value between reads
  always_ff @(posedge clk_sys_i) begin
    if (sel_i && !req_i.we) begin
      rdata_o <= mem_q[word_idx];
    end
  end

endmodule

`default_nettype wire

/* design/bus_addr_decode.sv */
// Decode stage: maps the request address to a device strobe and registers the pending access
`default_nettype none

module bus_addr_decode (
  input  wire                                 clk_sys_i,
  input  wire                                 rst_sys_ni,
  input  wire bus_pkg::bus_req_t              req_i,
  output logic [bus_pkg::NumDevices-1:0]      dev_sel_o,
  output logic                                pend_valid_o,
  output bus_pkg::bus_device_e                pend_dev_o,
  output logic                                pend_we_o
);

  // Access waiting for its response in the next cycle
  typedef struct packed {
    logic                 valid;
    bus_pkg::bus_device_e dev;
    logic                 we;
  } pend_t;

  bus_pkg::bus_device_e dev_hit;
  pend_t                pend_q;

  always_comb begin
    dev_hit = bus_pkg::DevNone;
    if ((req_i.addr & bus_pkg::WindowMask) == bus_pkg::RamBase) begin
      dev_hit = bus_pkg::DevRam;
    end else if ((req_i.addr & bus_pkg::WindowMask) == bus_pkg::GpioBase) begin
      dev_hit = bus_pkg::DevGpio;
    end else if ((req_i.addr & bus_pkg::WindowMask) == bus_pkg::TimerBase) begin
      dev_hit = bus_pkg::DevTimer;
    end
  end

  // Unmapped accesses strobe no device
  always_comb begin
    dev_sel_o = '0;
    if (req_i.valid && (dev_hit != bus_pkg::DevNone)) begin
      dev_sel_o[dev_hit] = 1'b1;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      pend_q <= '{valid: 1'b0, dev: bus_pkg::DevNone, we: 1'b0};
    end else begin
      pend_q <= '{valid: req_i.valid, dev: dev_hit, we: req_i.we};
    end
  end

  assign pend_valid_o = pend_q.valid;
  assign pend_dev_o   = pend_q.dev;
  assign pend_we_o    = pend_q.we;

  a_sel_onehot: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $onehot0(dev_sel_o));

endmodule

`default_nettype wire

/* design/bus_pkg.sv */
// Shared bus types, address map and register encodings for the system bus and its devices
`default_nettype none

package bus_pkg;

  // Bus widths
  localparam int DataWidth = 32;
  localparam int AddrWidth = 32;

  // Number of mapped devices, DevNone excluded
  localparam int NumDevices = 3;

  // Host request, valid for exactly one cycle
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [DataWidth/8-1:0] be;
    logic [AddrWidth-1:0]   addr;
    logic [DataWidth-1:0]   wdata;
  } bus_req_t;

  // Response, returned one cycle after the request
  typedef struct packed {
    logic                 rvalid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } bus_resp_t;

  // Device index, also the bit position in the select vector
  typedef enum logic [1:0] {
    DevRam   = 2'd0,
    DevGpio  = 2'd1,
    DevTimer = 2'd2,
    DevNone  = 2'd3
  } bus_device_e;

  // Address map, every window is 4 KiB
  localparam logic [AddrWidth-1:0] RamBase    = 32'h0010_0000;
  localparam logic [AddrWidth-1:0] GpioBase   = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] TimerBase  = 32'h8000_2000;
  localparam logic [AddrWidth-1:0] WindowMask = 32'hFFFF_F000;

  // GPIO registers, picked by address bit 2
  typedef enum logic {
    GpioOut = 1'b0,
    GpioIn  = 1'b1
  } gpio_reg_e;

  // Timer registers, picked by address bit 2
  typedef enum logic {
    TimerCount   = 1'b0,
    TimerCompare = 1'b1
  } timer_reg_e;

endpackage

`default_nettype wire
